// File: c64_loader_top.f
verilog/c64_loader_pkg.sv
verilog/download_parser.sv
verilog/write_fifo.sv
verilog/wb_mem_writer.sv
verilog/c64_loader_top.sv
verification/wb_mem_model.sv
verification/tb_c64_loader.sv

// File: Makefile
# Verilator build and run for the C64 loader testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_c64_loader
RTL_TOP   ?= c64_loader_top
FLIST     ?= c64_loader_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || (echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TB_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_c64_loader.sv
// Runs a PRG, a two packet CRT and a stalled PRG; expected writes come from the download rules
`timescale 1ns/10ps
`default_nettype none

module tb_c64_loader;

	localparam int PRG1_LEN = 20;
	localparam int PKT1_LEN = 37;
	localparam int PKT2_LEN = 20;
	localparam int PRG2_LEN = 24;
	localparam int TOTAL_BYTES = 2 + PRG1_LEN + 64 + 32 + PKT1_LEN + PKT2_LEN + 2 + PRG2_LEN;

	logic clk_sys = 1'b0;
	logic reset_n = 1'b0;
	logic dl_active_i = 1'b0;
	c64_loader_pkg::dl_index_t dl_index_i = '0;
	logic dl_wr_i = 1'b0;
	c64_loader_pkg::dl_offset_t dl_offset_i = '0;
	c64_loader_pkg::mem_data_t dl_data_i = '0;
	logic [3:0] ack_delay_max = 4'd5;
	wire dl_wait_o, bank_valid_o, cart_attached_o;
	wire c64_loader_pkg::bank_word_t cart_id_o, bank_num_o, bank_laddr_o, bank_size_o;
	wire c64_loader_pkg::mem_data_t cart_exrom_o, cart_game_o, bank_type_o, wb_dat_o;
	wire c64_loader_pkg::mem_addr_t bank_raddr_o, wb_adr_o;
	wire wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;

	int          err_count = 0;
	logic        wait_seen = 1'b0;
	logic [7:0]  file_q [$];
	logic [24:0] exp_addr [$];
	logic [7:0]  exp_data [$];
	logic [55:0] exp_bank [$];
	logic [24:0] exp_raddr [$];
	logic [24:0] crt_addr;

	c64_loader_top #(.FIFO_DEPTH(4)) dut0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i), .dl_offset_i(dl_offset_i),
		.dl_data_i(dl_data_i), .dl_wait_o(dl_wait_o), .cart_id_o(cart_id_o),
		.cart_exrom_o(cart_exrom_o), .cart_game_o(cart_game_o),
		.bank_valid_o(bank_valid_o), .bank_type_o(bank_type_o), .bank_num_o(bank_num_o),
		.bank_laddr_o(bank_laddr_o), .bank_size_o(bank_size_o),
		.bank_raddr_o(bank_raddr_o), .cart_attached_o(cart_attached_o),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_ack_i(wb_ack_i)
	);

	wb_mem_model mem0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o),
		.wb_we_i(wb_we_o), .wb_adr_i(wb_adr_o), .wb_dat_i(wb_dat_o),
		.max_delay_i(ack_delay_max), .wb_ack_o(wb_ack_i)
	);

	always #20 clk_sys = ~clk_sys;

	// ==================================================
	// Checks
	// ==================================================

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			err_count++;
			$display("FAILED at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
		end
	endtask

	a_wb_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o)))
		else begin
			err_count++;
			$display("Wishbone request dropped or changed before ack at %0t ns", $time);
		end

	a_wb_write: assert property (@(posedge clk_sys) disable iff (!reset_n)
		wb_stb_o |-> (wb_cyc_o && wb_we_o))
		else begin
			err_count++;
			$display("Wishbone strobe without cyc or we at %0t ns", $time);
		end

	a_bank_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_valid_o |=> !bank_valid_o)
		else begin
			err_count++;
			$display("bank_valid_o held longer than one cycle at %0t ns", $time);
		end

	// Each chip header pulse is matched against the next expected bank
	always @(posedge clk_sys) begin : bank_check
		logic [55:0] b;
		if (reset_n && bank_valid_o) begin
			if (exp_bank.size() == 0) begin
				err_count++;
				$display("Unexpected bank_valid_o pulse at %0t ns", $time);
			end else begin
				b = exp_bank.pop_front();
				check_value("bank_type_o", 32'(b[55:48]), 32'(bank_type_o));
				check_value("bank_num_o", 32'(b[47:32]), 32'(bank_num_o));
				check_value("bank_laddr_o", 32'(b[31:16]), 32'(bank_laddr_o));
				check_value("bank_size_o", 32'(b[15:0]), 32'(bank_size_o));
				check_value("bank_raddr_o", 32'(exp_raddr.pop_front()), 32'(bank_raddr_o));
			end
		end
	end

	// ==================================================
	// Stimulus tasks
	// ==================================================

	task automatic build_prg(input logic [15:0] load, input int n);
		logic [7:0] d;
		file_q.delete();
		file_q.push_back(load[7:0]);
		file_q.push_back(load[15:8]);
		for (int i = 0; i < n; i++) begin
			d = 8'(i * 13 + 5) ^ load[7:0];
			file_q.push_back(d);
			exp_addr.push_back(25'(load) + 25'(i));
			exp_data.push_back(d);
		end
	endtask

	task automatic add_packet(input logic [7:0] btype, input logic [15:0] num,
	                          input logic [15:0] laddr, input int len);
		logic [31:0] magic;
		logic [31:0] total;
		logic [7:0]  d;
		magic = "CHIP";
		total = 32'(len + 16);
		// Next 8 KB block when the previous payload ended inside one
		if (crt_addr[12:0] != '0)
			crt_addr = {crt_addr[24:13] + 12'd1, 13'd0};
		for (int s = 24; s >= 0; s -= 8) file_q.push_back(magic[s +: 8]);
		for (int s = 24; s >= 0; s -= 8) file_q.push_back(total[s +: 8]);
		file_q.push_back(8'h00);
		file_q.push_back(btype);
		file_q.push_back(num[15:8]);
		file_q.push_back(num[7:0]);
		file_q.push_back(laddr[15:8]);
		file_q.push_back(laddr[7:0]);
		file_q.push_back(8'(len >> 8));
		file_q.push_back(8'(len));
		exp_bank.push_back({btype, num, laddr, 16'(len)});
		exp_raddr.push_back(crt_addr);
		for (int i = 0; i < len; i++) begin
			d = 8'(i * 7 + 3) ^ num[7:0];
			file_q.push_back(d);
			exp_addr.push_back(crt_addr);
			exp_data.push_back(d);
			crt_addr = crt_addr + 25'd1;
		end
	endtask

	// Host holds each byte until an edge where the FIFO is not full
	task automatic send_file();
		logic stalled;
		for (int i = 0; i < file_q.size(); i++) begin
			dl_wr_i     = 1'b1;
			dl_offset_i = 25'(i);
			dl_data_i   = file_q[i];
			do begin
				@(negedge clk_sys);
				stalled = dl_wait_o;
				if (stalled) wait_seen = 1'b1;
				@(posedge clk_sys);
				#2;
			end while (stalled);
		end
		dl_wr_i = 1'b0;
	endtask

	task automatic set_active(input logic [7:0] idx, input logic act);
		@(posedge clk_sys);
		#2;
		dl_index_i  = idx;
		dl_active_i = act;
		repeat (2) @(posedge clk_sys);
		#2;
	endtask

	task automatic check_writes(input string what);
		while (mem0.log_addr.size() < exp_addr.size()) @(posedge clk_sys);
		repeat (10) @(posedge clk_sys);
		check_value({what, " write count"}, 32'(exp_addr.size()), 32'(mem0.log_addr.size()));
		for (int i = 0; i < exp_addr.size() && i < mem0.log_addr.size(); i++) begin
			check_value("wb_adr_o", 32'(exp_addr[i]), 32'(mem0.log_addr[i]));
			check_value("wb_dat_o", 32'(exp_data[i]), 32'(mem0.log_data[i]));
		end
		exp_addr.delete();
		exp_data.delete();
		mem0.log_addr.delete();
		mem0.log_data.delete();
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		repeat (200 * TOTAL_BYTES) @(posedge clk_sys);
		$display("Timeout: the downloads did not complete in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		repeat (3) @(posedge clk_sys);
		#2;
		reset_n = 1'b1;

		// PRG load
		build_prg(16'h0801, PRG1_LEN);
		set_active(c64_loader_pkg::IDX_PRG, 1'b1);
		send_file();
		set_active(c64_loader_pkg::IDX_PRG, 1'b0);
		check_writes("PRG");

		// CRT with two packets, the first one odd sized
		file_q.delete();
		for (int o = 0; o < 64; o++) file_q.push_back(8'hFF);
		file_q[8'h16] = 8'h12;
		file_q[8'h17] = 8'h34;
		file_q[8'h18] = 8'h01;
		file_q[8'h19] = 8'h00;
		crt_addr = 25'h100000;
		add_packet(8'h00, 16'h0000, 16'h8000, PKT1_LEN);
		add_packet(8'h02, 16'h0001, 16'hA000, PKT2_LEN);
		set_active(c64_loader_pkg::IDX_CRT, 1'b1);
		check_value("cart_attached_o", 32'd0, 32'(cart_attached_o));
		send_file();
		check_value("cart_attached_o", 32'd0, 32'(cart_attached_o));
		set_active(c64_loader_pkg::IDX_CRT, 1'b0);
		check_value("cart_attached_o", 32'd1, 32'(cart_attached_o));
		check_value("cart_id_o", 32'h1234, 32'(cart_id_o));
		check_value("cart_exrom_o", 32'h01, 32'(cart_exrom_o));
		check_value("cart_game_o", 32'h00, 32'(cart_game_o));
		check_writes("CRT");
		check_value("bank pulses missing", 32'd0, 32'(exp_bank.size()));

		// PRG under back-pressure
		ack_delay_max = 4'd12;
		wait_seen     = 1'b0;
		build_prg(16'hC000, PRG2_LEN);
		set_active(c64_loader_pkg::IDX_PRG, 1'b1);
		send_file();
		set_active(c64_loader_pkg::IDX_PRG, 1'b0);
		check_writes("stalled PRG");
		check_value("dl_wait_o seen", 32'd1, 32'(wait_seen));
		check_value("cart_attached_o", 32'd1, 32'(cart_attached_o));

		// A new CRT download drops the attached cartridge
		set_active(c64_loader_pkg::IDX_CRT_ALT, 1'b1);
		check_value("cart_attached_o", 32'd0, 32'(cart_attached_o));
		set_active(c64_loader_pkg::IDX_CRT_ALT, 1'b0);

		$display("Errors: %0d", err_count);
		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/wb_mem_model.sv
// Wishbone classic slave that only logs writes; ack delay is random from 0 to max_delay_i cycles
`timescale 1ns/10ps
`default_nettype none

module wb_mem_model #(
	parameter int SEED = 16467
) (
	input  wire        clk_sys,
	input  wire        reset_n,
	input  wire        wb_cyc_i,
	input  wire        wb_stb_i,
	input  wire        wb_we_i,
	input  wire [24:0] wb_adr_i,
	input  wire [7:0]  wb_dat_i,
	input  wire [3:0]  max_delay_i,
	output logic       wb_ack_o
);

	// Write log, read by the testbench
	logic [24:0] log_addr [$];
	logic [7:0]  log_data [$];

	int   wait_cnt;
	logic armed;

	initial begin
		void'($urandom(SEED));
	end

	// ==================================================
	// Acknowledge generation
	// ==================================================

	always @(posedge clk_sys) begin : ack_gen
		int delay;
		if (!reset_n) begin
			wb_ack_o <= 1'b0;
			armed    <= 1'b0;
			wait_cnt <= 0;
		end else if (wb_ack_o) begin
			wb_ack_o <= 1'b0;
			armed    <= 1'b0;
		end else if (wb_cyc_i && wb_stb_i) begin
			if (!armed) begin
				delay = int'($urandom % (32'(max_delay_i) + 1));
				if (delay == 0) begin
					wb_ack_o <= 1'b1;
				end else begin
					wait_cnt <= delay - 1;
					armed    <= 1'b1;
				end
			end else if (wait_cnt == 0) begin
				wb_ack_o <= 1'b1;
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end

		// A write completes on the edge where ack is seen
		if (reset_n && wb_ack_o && wb_cyc_i && wb_stb_i && wb_we_i) begin
			log_addr.push_back(wb_adr_i);
			log_data.push_back(wb_dat_i);
		end
	end

endmodule

`default_nettype wire

// File: verilog/c64_loader_top.sv
// Single clock domain; host must hold its byte while dl_wait_o is high
`timescale 1ns/10ps
`default_nettype none

module c64_loader_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                             clk_sys,
	input  wire                             reset_n,
	// Host download port
	input  wire                             dl_active_i,
	input  wire  c64_loader_pkg::dl_index_t  dl_index_i,
	input  wire                             dl_wr_i,
	input  wire  c64_loader_pkg::dl_offset_t dl_offset_i,
	input  wire  c64_loader_pkg::mem_data_t  dl_data_i,
	output wire                             dl_wait_o,
	// Cartridge status
	output wire  c64_loader_pkg::bank_word_t cart_id_o,
	output wire  c64_loader_pkg::mem_data_t  cart_exrom_o,
	output wire  c64_loader_pkg::mem_data_t  cart_game_o,
	output wire                             bank_valid_o,
	output wire  c64_loader_pkg::mem_data_t  bank_type_o,
	output wire  c64_loader_pkg::bank_word_t bank_num_o,
	output wire  c64_loader_pkg::bank_word_t bank_laddr_o,
	output wire  c64_loader_pkg::bank_word_t bank_size_o,
	output wire  c64_loader_pkg::mem_addr_t  bank_raddr_o,
	output wire                             cart_attached_o,
	// Wishbone master
	output wire                             wb_cyc_o,
	output wire                             wb_stb_o,
	output wire                             wb_we_o,
	output wire  c64_loader_pkg::mem_addr_t  wb_adr_o,
	output wire  c64_loader_pkg::mem_data_t  wb_dat_o,
	input  wire                             wb_ack_i
);

	wire                            push;
	wire c64_loader_pkg::mem_addr_t push_addr;
	wire c64_loader_pkg::mem_data_t push_data;
	wire                            pop;
	wire c64_loader_pkg::mem_addr_t head_addr;
	wire c64_loader_pkg::mem_data_t head_data;
	wire                            fifo_empty;

	download_parser parser0 (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_offset_i(dl_offset_i), .dl_data_i(dl_data_i), .dl_wait_i(dl_wait_o),
		.push_o(push), .push_addr_o(push_addr), .push_data_o(push_data),
		.cart_id_o(cart_id_o), .cart_exrom_o(cart_exrom_o), .cart_game_o(cart_game_o),
		.bank_valid_o(bank_valid_o), .bank_type_o(bank_type_o), .bank_num_o(bank_num_o),
		.bank_laddr_o(bank_laddr_o), .bank_size_o(bank_size_o),
		.bank_raddr_o(bank_raddr_o), .cart_attached_o(cart_attached_o)
	);

	// Full flag doubles as the host stall
	write_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.push_i(push), .push_addr_i(push_addr), .push_data_i(push_data),
		.pop_i(pop), .head_addr_o(head_addr), .head_data_o(head_data),
		.empty_o(fifo_empty), .full_o(dl_wait_o)
	);

	wb_mem_writer writer0 (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.empty_i(fifo_empty), .head_addr_i(head_addr), .head_data_i(head_data),
		.pop_o(pop), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_ack_i(wb_ack_i)
	);

endmodule

`default_nettype wire

// File: verilog/wb_mem_writer.sv
// Wishbone classic single writes only; one idle cycle always follows each acknowledge
`timescale 1ns/10ps
`default_nettype none

module wb_mem_writer (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire                            empty_i,
	input  wire c64_loader_pkg::mem_addr_t  head_addr_i,
	input  wire c64_loader_pkg::mem_data_t  head_data_i,
	output logic                           pop_o,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output c64_loader_pkg::mem_addr_t       wb_adr_o,
	output c64_loader_pkg::mem_data_t       wb_dat_o,
	input  wire                            wb_ack_i
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} wr_state_t;

	wr_state_t state;

	// ==================================================
	// Bus cycle FSM
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (!empty_i) state <= ST_BUSY;
				ST_BUSY: if (wb_ack_i) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Head entry is held for the whole cycle
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && !empty_i) begin
			wb_adr_o <= head_addr_i;
			wb_dat_o <= head_data_i;
		end
	end

	assign wb_cyc_o = (state == ST_BUSY);
	assign wb_stb_o = (state == ST_BUSY);
	assign wb_we_o  = (state == ST_BUSY);
	// Entry leaves the FIFO on the ack edge
	assign pop_o    = (state == ST_BUSY) && wb_ack_i;

	a_hold_until_ack: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o)))
		else $error("wb_mem_writer: request changed before ack");

endmodule

`default_nettype wire

// File: verilog/write_fifo.sv
// FIFO_DEPTH must be a power of two of at least 2; full_o already counts a push in flight
`timescale 1ns/10ps
`default_nettype none

module write_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire                            push_i,
	input  wire c64_loader_pkg::mem_addr_t  push_addr_i,
	input  wire c64_loader_pkg::mem_data_t  push_data_i,
	input  wire                            pop_i,
	output c64_loader_pkg::mem_addr_t       head_addr_o,
	output c64_loader_pkg::mem_data_t       head_data_o,
	output logic                           empty_o,
	output logic                           full_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] CNT_FULL = (PTR_W + 1)'(FIFO_DEPTH);

	c64_loader_pkg::mem_addr_t addr_mem [FIFO_DEPTH];
	c64_loader_pkg::mem_data_t data_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;

	// Storage
	always_ff @(posedge clk_sys) begin
		if (push_i) begin
			addr_mem[wr_ptr] <= push_addr_i;
			data_mem[wr_ptr] <= push_data_i;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_addr_o = addr_mem[rd_ptr];
	assign head_data_o = data_mem[rd_ptr];
	assign empty_o     = (count == '0);
	// The producer pushes one cycle after it takes a byte
	// so the last free slot counts as taken while that push is pending
	assign full_o      = (count == CNT_FULL) || (push_i && count == CNT_FULL - 1'b1);

	a_no_overflow: assert property (@(posedge clk_sys) disable iff (!reset_n)
		push_i |-> (count != CNT_FULL))
		else $error("write_fifo: push into a full FIFO");

	a_no_underflow: assert property (@(posedge clk_sys) disable iff (!reset_n)
		pop_i |-> !empty_o)
		else $error("write_fifo: pop from an empty FIFO");

endmodule

`default_nettype wire

// File: verilog/download_parser.sv
// Accepts bytes whenever dl_wr_i is high and dl_wait_i low; CRT packets must be at least 16 bytes long
`timescale 1ns/10ps
`default_nettype none

module download_parser (
	input  wire                             clk_sys,
	input  wire                             reset_n,
	input  wire                             dl_active_i,
	input  wire  c64_loader_pkg::dl_index_t  dl_index_i,
	input  wire                             dl_wr_i,
	input  wire  c64_loader_pkg::dl_offset_t dl_offset_i,
	input  wire  c64_loader_pkg::mem_data_t  dl_data_i,
	input  wire                             dl_wait_i,
	output logic                            push_o,
	output c64_loader_pkg::mem_addr_t        push_addr_o,
	output c64_loader_pkg::mem_data_t        push_data_o,
	output c64_loader_pkg::bank_word_t       cart_id_o,
	output c64_loader_pkg::mem_data_t        cart_exrom_o,
	output c64_loader_pkg::mem_data_t        cart_game_o,
	output logic                            bank_valid_o,
	output c64_loader_pkg::mem_data_t        bank_type_o,
	output c64_loader_pkg::bank_word_t       bank_num_o,
	output c64_loader_pkg::bank_word_t       bank_laddr_o,
	output c64_loader_pkg::bank_word_t       bank_size_o,
	output c64_loader_pkg::mem_addr_t        bank_raddr_o,
	output logic                            cart_attached_o
);

	localparam c64_loader_pkg::mem_addr_t ALIGN_MASK =
		c64_loader_pkg::mem_addr_t'((1 << c64_loader_pkg::CRT_ALIGN_BITS) - 1);
	localparam logic [3:0] HDR_LAST = 4'(c64_loader_pkg::CHIP_HDR_LEN - 1);

	c64_loader_pkg::mem_addr_t   load_addr;
	c64_loader_pkg::blk_len_t    blk_len;
	c64_loader_pkg::chip_phase_t phase;
	logic [3:0]                  hdr_cnt;
	logic                        dl_active_d;

	logic accept;
	logic is_prg;
	logic is_crt;
	logic crt_byte;
	logic chip_byte;
	logic seek_byte;
	logic hdr_byte;
	logic data_byte;
	logic prg_data;
	logic wr_byte;

	// ==================================================
	// Byte decode
	// ==================================================

	assign accept    = dl_wr_i && !dl_wait_i;
	assign is_prg    = (dl_index_i == c64_loader_pkg::IDX_PRG);
	assign is_crt    = (dl_index_i == c64_loader_pkg::IDX_CRT) ||
	                   (dl_index_i == c64_loader_pkg::IDX_CRT_ALT);
	assign crt_byte  = accept && is_crt;
	assign chip_byte = crt_byte && (dl_offset_i >= c64_loader_pkg::CRT_OFS_CHIPS);
	assign seek_byte = chip_byte && (phase == c64_loader_pkg::CHIP_SEEK);
	assign hdr_byte  = chip_byte && (phase == c64_loader_pkg::CHIP_HEADER);
	assign data_byte = chip_byte && (phase == c64_loader_pkg::CHIP_DATA);
	// First two PRG bytes are the load address
	assign prg_data  = accept && is_prg && (dl_offset_i > 25'd1);
	assign wr_byte   = prg_data || data_byte;

	// ==================================================
	// Control state
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			push_o          <= 1'b0;
			bank_valid_o    <= 1'b0;
			cart_attached_o <= 1'b0;
			dl_active_d     <= 1'b0;
			phase           <= c64_loader_pkg::CHIP_SEEK;
			hdr_cnt         <= '0;
		end else begin
			push_o       <= wr_byte;
			bank_valid_o <= hdr_byte && (hdr_cnt == HDR_LAST);
			dl_active_d  <= dl_active_i;

			// Start of download clears the mark, end of download sets it
			if (dl_active_d != dl_active_i && is_crt)
				cart_attached_o <= dl_active_d;

			if (crt_byte && dl_offset_i == '0) begin
				phase   <= c64_loader_pkg::CHIP_SEEK;
				hdr_cnt <= '0;
			end else if (seek_byte) begin
				phase   <= c64_loader_pkg::CHIP_HEADER;
				hdr_cnt <= 4'd1;
			end else if (hdr_byte) begin
				hdr_cnt <= hdr_cnt + 4'd1;
				// An empty packet goes straight to the next header
				if (hdr_cnt == HDR_LAST)
					phase <= (blk_len == '0) ? c64_loader_pkg::CHIP_SEEK
					                         : c64_loader_pkg::CHIP_DATA;
			end else if (data_byte && blk_len == 32'd1) begin
				phase <= c64_loader_pkg::CHIP_SEEK;
			end
		end
	end

	// ==================================================
	// Addresses, lengths and header fields
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (wr_byte) begin
			push_addr_o <= load_addr;
			push_data_o <= dl_data_i;
			load_addr   <= load_addr + 25'd1;
		end

		if (accept && is_prg && dl_offset_i == '0)
			load_addr <= {17'd0, dl_data_i};
		if (accept && is_prg && dl_offset_i == 25'd1)
			load_addr[15:8] <= dl_data_i;

		if (crt_byte) begin
			if (dl_offset_i == '0) begin
				load_addr <= c64_loader_pkg::CRT_LOAD_BASE;
				blk_len   <= '0;
			end
			if (dl_offset_i == c64_loader_pkg::CRT_OFS_ID_HI) cart_id_o[15:8] <= dl_data_i;
			if (dl_offset_i == c64_loader_pkg::CRT_OFS_ID_LO) cart_id_o[7:0]  <= dl_data_i;
			if (dl_offset_i == c64_loader_pkg::CRT_OFS_EXROM) cart_exrom_o    <= dl_data_i;
			if (dl_offset_i == c64_loader_pkg::CRT_OFS_GAME)  cart_game_o     <= dl_data_i;
		end

		// Round up to the next 8 KB boundary
		if (seek_byte && (load_addr & ALIGN_MASK) != '0)
			load_addr <= (load_addr | ALIGN_MASK) + 25'd1;

		if (hdr_byte) begin
			case (hdr_cnt)
				4'd4:  blk_len[31:24]     <= dl_data_i;
				4'd5:  blk_len[23:16]     <= dl_data_i;
				4'd6:  blk_len[15:8]      <= dl_data_i;
				4'd7:  blk_len[7:0]       <= dl_data_i;
				4'd8:  blk_len <= blk_len - 32'(c64_loader_pkg::CHIP_HDR_LEN);
				4'd9:  bank_type_o        <= dl_data_i;
				4'd10: bank_num_o[15:8]   <= dl_data_i;
				4'd11: bank_num_o[7:0]    <= dl_data_i;
				4'd12: bank_laddr_o[15:8] <= dl_data_i;
				4'd13: bank_laddr_o[7:0]  <= dl_data_i;
				4'd14: bank_size_o[15:8]  <= dl_data_i;
				4'd15: begin
					bank_size_o[7:0] <= dl_data_i;
					bank_raddr_o     <= load_addr;
				end
				default: ;
			endcase
		end

		if (data_byte)
			blk_len <= blk_len - 32'd1;
	end

	// A stalled host keeps offering the same byte until it is taken
	a_host_holds: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(dl_wr_i && dl_wait_i) |=> (dl_wr_i && $stable(dl_offset_i) && $stable(dl_data_i)))
		else $error("download_parser: host changed its byte while stalled");

endmodule

`default_nettype wire

// File: verilog/c64_loader_pkg.sv
// Shared widths and CRT layout for the loader; CRT constants follow the standard cartridge image format
`default_nettype none

package c64_loader_pkg;

	// ==================================================
	// Widths
	// ==================================================

	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  mem_data_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_offset_t;
	typedef logic [15:0] bank_word_t;
	typedef logic [31:0] blk_len_t;

	// ==================================================
	// Download file types
	// ==================================================

	localparam dl_index_t IDX_PRG     = 8'd4;
	localparam dl_index_t IDX_CRT     = 8'd5;
	localparam dl_index_t IDX_CRT_ALT = 8'hC0;

	// ==================================================
	// CRT image layout
	// ==================================================

	// Cartridge payload lives above the 1 MB mark
	localparam mem_addr_t CRT_LOAD_BASE  = 25'h100000;
	localparam int        CRT_ALIGN_BITS = 13;

	// File header fields
	localparam dl_offset_t CRT_OFS_ID_HI = 25'h16;
	localparam dl_offset_t CRT_OFS_ID_LO = 25'h17;
	localparam dl_offset_t CRT_OFS_EXROM = 25'h18;
	localparam dl_offset_t CRT_OFS_GAME  = 25'h19;
	localparam dl_offset_t CRT_OFS_CHIPS = 25'h40;

	// Size of each CHIP packet header
	localparam int CHIP_HDR_LEN = 16;

	// Where the parser stands inside the chip packet stream
	typedef enum logic [1:0] {
		CHIP_SEEK,
		CHIP_HEADER,
		CHIP_DATA
	} chip_phase_t;

endpackage

`default_nettype wire
